// File: files.f
conv_geom_pkg.sv
tuser_pkg.sv
pad_ctrl_if.sv
tuser_decode.sv
pad_filter.sv
pad_output_stage.sv
conv_pad_top.sv
tb_pad_checker.sv
tb_conv_pad.sv

// File: tb_conv_pad.sv
// testbench top for the padding stage: clock, reset, random rows of beats and a run limit
`timescale 1ns/1ps

module tb_conv_pad
    import conv_geom_pkg::*, tuser_pkg::*;
();

    localparam int N_ROWS = 24;
    // a row is at most 11 beats and each beat may sit behind a gap
    localparam int MAX_CYCLES = N_ROWS * 12 * 4 + 100;

    logic                               aclk;
    logic                               rst;
    logic                               aclken;
    logic                               valid_in;
    logic [TUSER_WIDTH-1:0]             user_in;
    logic [MEMBERS-1:0][DATA_WIDTH-1:0] data_in;
    logic                               cfg_error;
    logic                               m_valid;
    logic [MEMBERS-1:0][DATA_WIDTH-1:0] m_data;
    logic [MEMBERS-1:0][BITS_KW-1:0]    m_clr;
    logic [BITS_MEMBERS-1:0]            m_shift_a;
    logic [BITS_OUT_SHIFT-1:0]          m_shift_b;
    logic                               done;
    logic                               report_done;
    int                                 err_count;
    logic [15:0]                        lfsr;
    int                                 cycles = 0;

    conv_pad_top #(
        .KW_MAX     (KW_MAX),
        .SW_MAX     (SW_MAX),
        .MEMBERS    (MEMBERS),
        .DATA_WIDTH (DATA_WIDTH)
    ) uut (
        .aclk       (aclk),
        .rst        (rst),
        .aclken     (aclken),
        .valid_in   (valid_in),
        .user_in    (user_in),
        .data_in    (data_in),
        .cfg_error  (cfg_error),
        .m_valid    (m_valid),
        .m_data     (m_data),
        .m_clr      (m_clr),
        .m_shift_a  (m_shift_a),
        .m_shift_b  (m_shift_b)
    );

    tb_pad_checker u_checker (
        .aclk        (aclk),
        .rst         (rst),
        .aclken      (aclken),
        .valid_in    (valid_in),
        .user_in     (user_in),
        .data_in     (data_in),
        .cfg_error   (cfg_error),
        .m_valid     (m_valid),
        .m_data      (m_data),
        .m_clr       (m_clr),
        .m_shift_a   (m_shift_a),
        .m_shift_b   (m_shift_b),
        .done        (done),
        .report_done (report_done),
        .err_count   (err_count)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [TUSER_WIDTH-1:0] make_user(input int kw2, input int sw_1,
            input logic cfg, input logic cin_last, input logic c1k2, input logic col_valid);
        logic [TUSER_WIDTH-1:0] u;
        u = '0;
        u[I_KW2 +: BITS_KW2] = BITS_KW2'(kw2);
        u[I_SW_1 +: BITS_SW] = BITS_SW'(sw_1);
        u[I_IS_CONFIG]       = cfg;
        u[I_IS_CIN_LAST]     = cin_last;
        u[I_IS_COLS_1_K2]    = c1k2;
        u[I_IS_COL_VALID]    = col_valid;
        return u;
    endfunction

    // a quarter of the beats wait one or two cycles with the clock enable low
    task automatic send_beat(input logic [TUSER_WIDTH-1:0] user, input logic [63:0] data);
        logic [63:0] r;
        int          gap;
        rand_bits(3, r);
        gap = (r[1:0] == 2'd0) ? 1 + int'(r[2]) : 0;
        for (int i = 0; i < gap; i++) begin
            rand_bits(1 + TUSER_WIDTH, r);
            // strobe, user word and data wander while the enable is low
            aclken   = 1'b0;
            valid_in = r[0];
            user_in  = r[TUSER_WIDTH:1];
            rand_bits(64, r);
            data_in  = r;
            @(posedge aclk);
            #2;
        end
        aclken   = 1'b1;
        valid_in = 1'b1;
        user_in  = user;
        data_in  = data;
        @(posedge aclk);
        #2;
    endtask

    initial begin
        logic [63:0] r;
        logic [63:0] data;
        logic        col_valid;
        int          kw2;
        int          prev_kw2;
        int          sw_1;
        int          cols;
        aclken   = 1'b0;
        valid_in = 1'b0;
        user_in  = '0;
        data_in  = '0;
        rst      = 1'b1;
        done     = 1'b0;
        lfsr     = 16'd5;
        prev_kw2 = 0;
        repeat (16) @(posedge aclk);
        #2;
        rst = 1'b0;

        for (int row = 0; row < N_ROWS; row++) begin
            rand_bits(6, r);
            kw2  = int'(r[1:0]);
            sw_1 = int'(r[2]);
            cols = 4 + int'(r[5:3]) % 7;
            // the end pulse left over from a kw2 = 1 row would meet a kw2 = 3 start
            if (prev_kw2 == 1 && kw2 == 3) begin
                kw2 = 2;
            end
            prev_kw2 = kw2;
            rand_bits(64, data);
            send_beat(make_user(kw2, sw_1, 1'b1, 1'b0, 1'b0, 1'b0), data);
            for (int c = 0; c < cols; c++) begin
                rand_bits(3, r);
                // about one column in eight carries no pixels
                col_valid = (r[2:0] != 3'd0);
                rand_bits(64, data);
                send_beat(make_user(kw2, sw_1, 1'b0, 1'b1, c == cols - 1 - kw2, col_valid),
                          data);
            end
        end

        valid_in = 1'b0;
        repeat (4) @(posedge aclk);
        #2;
        done = 1'b1;
        wait (report_done);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // run limit
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped: no result after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

// File: tb_pad_checker.sv
// scoreboard for the padding stage: cycle model of the pad rules, output compare and row report
`timescale 1ns/1ps

module tb_pad_checker
    import conv_geom_pkg::*, tuser_pkg::*;
(
    input  logic                               aclk,
    input  logic                               rst,
    input  logic                               aclken,
    input  logic                               valid_in,
    input  logic [TUSER_WIDTH-1:0]             user_in,
    input  logic [MEMBERS-1:0][DATA_WIDTH-1:0] data_in,
    input  logic                               cfg_error,
    input  logic                               m_valid,
    input  logic [MEMBERS-1:0][DATA_WIDTH-1:0] m_data,
    input  logic [MEMBERS-1:0][BITS_KW-1:0]    m_clr,
    input  logic [BITS_MEMBERS-1:0]            m_shift_a,
    input  logic [BITS_OUT_SHIFT-1:0]          m_shift_b,
    input  logic                               done,
    output logic                               report_done,
    output int                                 err_count
);

    // model state, chain positions count columns since the pulse entered (0 = empty)
    int start_pos;
    int end_pos;
    int left_code;
    int lane_end [MEMBERS];

    // outputs predicted for the next rising edge
    logic                               exp_valid;
    logic [MEMBERS-1:0][DATA_WIDTH-1:0] exp_data;
    logic [MEMBERS-1:0][BITS_KW-1:0]    exp_clr;
    int                                 exp_sa;
    int                                 exp_sb;

    // bookkeeping
    logic armed = 1'b0;
    logic reported = 1'b0;
    int   errs = 0;
    int   checks = 0;
    int   rows = 0;
    int   holds = 0;
    int   row = 0;
    int   row_errs = 0;
    int   row_kw2;
    int   row_sw_1;
    int   row_cols;

    assign report_done = reported;
    assign err_count   = errs;

    // left pad code for a row start p columns back, nothing for a 1-wide kernel
    function automatic int left_of(input int p, input int kw2);
        int c;
        c = 2 * p - 1 + (2 * kw2 + 1) - KW_MAX;
        if (kw2 == 0 || c < 0) begin
            c = 0;
        end
        return c;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("** Error row %0d %s: expected %h actual %h", row, name, exp, act);
            errs++;
            row_errs++;
        end
    endtask

    task automatic close_row();
        rows++;
        if (row_errs == 0) begin
            $display("row %0d kw2=%0d sw_1=%0d cols=%0d: ok", row, row_kw2, row_sw_1, row_cols);
        end else begin
            $display("row %0d kw2=%0d sw_1=%0d cols=%0d: %0d errors",
                     row, row_kw2, row_sw_1, row_cols, row_errs);
        end
        row_errs = 0;
    endtask

    // sample at the falling edge, where inputs and registered outputs are both settled
    always @(negedge aclk) begin : model
        logic                            beat;
        logic                            is_cfg;
        logic                            is_last;
        logic                            bad;
        logic                            vm;
        int                              kw2;
        int                              sw_1;
        int                              next_end;
        logic [MEMBERS-1:0][BITS_KW-1:0] clr;

        // outputs now show what the last sample predicted
        if (armed) begin
            check("m_valid", exp_valid, m_valid);
            if (exp_valid) begin
                check("m_data", exp_data, m_data);
                check("m_clr", exp_clr, m_clr);
                check("m_shift_a", exp_sa, m_shift_a);
                check("m_shift_b", exp_sb, m_shift_b);
            end
        end

        beat    = aclken && valid_in;
        kw2     = int'(user_in[I_KW2 +: BITS_KW2]);
        sw_1    = int'(user_in[I_SW_1 +: BITS_SW]);
        // kernels wider than the build fall back to kw = 1
        bad     = kw2 > KW2_MAX;
        if (bad) begin
            kw2 = 0;
        end
        is_cfg  = beat && user_in[I_IS_CONFIG];
        is_last = beat && !user_in[I_IS_CONFIG] && user_in[I_IS_CIN_LAST];

        if (armed) begin
            check("cfg_error", beat && bad, cfg_error);
        end
        if (armed && !rst && !aclken) begin
            holds++;
        end

        // a config beat opens a new row
        if (is_cfg && !rst) begin
            if (row > 0) begin
                close_row();
            end else begin
                row_errs = 0;
            end
            row++;
            row_kw2  = kw2;
            row_sw_1 = sw_1;
            row_cols = 0;
        end
        if (is_last && !rst) begin
            row_cols++;
        end

        // codes from the state before this edge, right code is twice the end position
        for (int m = 0; m < MEMBERS; m++) begin
            clr[m] = (kw2 == 0) ? '0 : BITS_KW'(left_code | (2 * lane_end[m]));
        end
        vm = is_cfg || (user_in[I_IS_COL_VALID] && !(start_pos != 0 && start_pos <= kw2));

        // end pulse enters at cols-1-kw2 and walks up one place per column
        if (user_in[I_IS_COLS_1_K2] && kw2 != 0) begin
            next_end = 1;
        end else if (end_pos > 0 && end_pos < KW2_MAX) begin
            next_end = end_pos + 1;
        end else begin
            next_end = 0;
        end

        if (rst) begin
            start_pos = 0;
            end_pos   = 0;
            left_code = 1;
            for (int m = 0; m < MEMBERS; m++) begin
                lane_end[m] = 0;
            end
            exp_valid = 1'b0;
            armed     = 1'b1;
        end else if (beat) begin
            exp_valid = vm;
            if (vm) begin
                exp_data = data_in;
                exp_clr  = clr;
                exp_sa   = (kw2 != 0 && end_pos == kw2) ? kw2 : 0;
                exp_sb   = (kw2 == 0) ? 0 : MEMBERS / (2 * kw2 + 1 + sw_1) - 1;
            end
            // lane copies follow the end chain only one lane short of a full window
            if (is_last) begin
                for (int m = 0; m < MEMBERS; m++) begin
                    if (kw2 == 0 || (m % (2 * kw2 + 1)) == 2 * kw2 - 1) begin
                        lane_end[m] = next_end;
                    end
                end
            end
            if (is_cfg || is_last) begin
                left_code = (start_pos != 0) ? left_of(start_pos, kw2) : 0;
                if (is_cfg) begin
                    start_pos = (kw2 != 0) ? 1 : 0;
                end else if (kw2 != 0 && end_pos == kw2) begin
                    // end of a row starts the next one
                    start_pos = 1;
                end else if (start_pos > 0 && start_pos < KW2_MAX) begin
                    start_pos = start_pos + 1;
                end else begin
                    start_pos = 0;
                end
                end_pos = next_end;
            end
        end

        if (done && !reported) begin
            close_row();
            $display("rows %0d, checks %0d, hold cycles %0d, errors %0d",
                     rows, checks, holds, errs);
            reported = 1'b1;
        end
    end

endmodule

// File: conv_pad_top.sv
// padding stage top: user word decode, pad mask computation and output register
`timescale 1ns/1ps

module conv_pad_top
    import conv_geom_pkg::*, tuser_pkg::*;
#(
    parameter int KW_MAX     = conv_geom_pkg::KW_MAX,
    parameter int SW_MAX     = conv_geom_pkg::SW_MAX,
    parameter int MEMBERS    = conv_geom_pkg::MEMBERS,
    parameter int DATA_WIDTH = conv_geom_pkg::DATA_WIDTH
) (
    input  logic                               aclk,
    input  logic                               rst,
    input  logic                               aclken,
    input  logic                               valid_in,
    input  logic [TUSER_WIDTH-1:0]             user_in,
    input  logic [MEMBERS-1:0][DATA_WIDTH-1:0] data_in,
    output logic                               cfg_error,
    output logic                               m_valid,
    output logic [MEMBERS-1:0][DATA_WIDTH-1:0] m_data,
    output logic [MEMBERS-1:0][BITS_KW-1:0]    m_clr,
    output logic [BITS_MEMBERS-1:0]            m_shift_a,
    output logic [BITS_OUT_SHIFT-1:0]          m_shift_b
);

    // decoded beat shared by all three stages
    pad_ctrl_if ctrl ();

    logic [MEMBERS-1:0][BITS_KW-1:0] clr;
    logic                            valid_mask;
    logic [BITS_MEMBERS-1:0]         shift_a;
    logic [BITS_OUT_SHIFT-1:0]       shift_b;

    tuser_decode #(
        .KW_MAX     (KW_MAX)
    ) u_decode (
        .aclk       (aclk),
        .rst        (rst),
        .aclken     (aclken),
        .valid_in   (valid_in),
        .user_in    (user_in),
        .cfg_error  (cfg_error),
        .ctrl       (ctrl.dec)
    );

    pad_filter #(
        .KW_MAX     (KW_MAX),
        .SW_MAX     (SW_MAX),
        .MEMBERS    (MEMBERS)
    ) u_filter (
        .aclk       (aclk),
        .rst        (rst),
        .ctrl       (ctrl.exe),
        .clr        (clr),
        .valid_mask (valid_mask),
        .shift_a    (shift_a),
        .shift_b    (shift_b)
    );

    // one register between the mask logic and the outputs
    pad_output_stage #(
        .DATA_WIDTH (DATA_WIDTH),
        .MEMBERS    (MEMBERS)
    ) u_output (
        .aclk       (aclk),
        .rst        (rst),
        .ctrl       (ctrl.res),
        .data_in    (data_in),
        .clr        (clr),
        .valid_mask (valid_mask),
        .shift_a    (shift_a),
        .shift_b    (shift_b),
        .m_valid    (m_valid),
        .m_data     (m_data),
        .m_clr      (m_clr),
        .m_shift_a  (m_shift_a),
        .m_shift_b  (m_shift_b)
    );

endmodule

// File: pad_output_stage.sv
// output register stage: keeps accepted beats with their pad masks, drops masked columns
`timescale 1ns/1ps

module pad_output_stage
    import conv_geom_pkg::*, tuser_pkg::*;
#(
    parameter int DATA_WIDTH = conv_geom_pkg::DATA_WIDTH,
    parameter int MEMBERS    = conv_geom_pkg::MEMBERS
) (
    input  logic                               aclk,
    input  logic                               rst,
    pad_ctrl_if.res                            ctrl,
    input  logic [MEMBERS-1:0][DATA_WIDTH-1:0] data_in,
    input  logic [MEMBERS-1:0][BITS_KW-1:0]    clr,
    input  logic                               valid_mask,
    input  logic [BITS_MEMBERS-1:0]            shift_a,
    input  logic [BITS_OUT_SHIFT-1:0]          shift_b,
    output logic                               m_valid,
    output logic [MEMBERS-1:0][DATA_WIDTH-1:0] m_data,
    output logic [MEMBERS-1:0][BITS_KW-1:0]    m_clr,
    output logic [BITS_MEMBERS-1:0]            m_shift_a,
    output logic [BITS_OUT_SHIFT-1:0]          m_shift_b
);

    logic take;

    // beat that survives the column mask
    assign take = ctrl.beat && valid_mask;

    // valid follows the mask of each beat and holds between beats
    always_ff @(posedge aclk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (ctrl.beat) begin
            m_valid <= valid_mask;
        end
    end

    // payload and masks only move with an accepted beat
    always_ff @(posedge aclk) begin
        if (take) begin
            m_data    <= data_in;
            m_clr     <= clr;
            m_shift_a <= shift_a;
            m_shift_b <= shift_b;
        end
    end

    // a config beat is always forwarded one cycle later
    assert property (@(posedge aclk) disable iff (rst)
        (ctrl.beat && ctrl.kind == BEAT_CONFIG) |=> m_valid)
        else $error("config beat lost in the output stage");

    // valid is never unknown once reset is released
    assert property (@(posedge aclk) disable iff (rst) !$isunknown(m_valid))
        else $error("m_valid is unknown");

endmodule

// File: pad_filter.sv
// horizontal pad filter: column start/end chains, per-lane clr codes, valid mask and shifts
`timescale 1ns/1ps

module pad_filter
    import conv_geom_pkg::*, tuser_pkg::*;
#(
    parameter int KW_MAX  = conv_geom_pkg::KW_MAX,
    parameter int SW_MAX  = conv_geom_pkg::SW_MAX,
    parameter int MEMBERS = conv_geom_pkg::MEMBERS
) (
    input  logic                            aclk,
    input  logic                            rst,
    pad_ctrl_if.exe                         ctrl,
    output logic [MEMBERS-1:0][BITS_KW-1:0] clr,
    output logic                            valid_mask,
    output logic [BITS_MEMBERS-1:0]         shift_a,
    output logic [BITS_OUT_SHIFT-1:0]       shift_b
);

    localparam int KW2_LIM = KW_MAX / 2;

    logic is_config;
    logic is_cin_last;
    logic reg_en;

    // chains are indexed from 1 so kw2 selects a bit directly
    logic [KW2_LIM:1] col_end_in;
    logic [KW2_LIM:1] col_end_q;
    logic [KW2_LIM:0] col_end;
    logic [KW2_LIM:1] col_start_in;
    logic [KW2_LIM:1] col_start;

    // per-lane copy of the end chain, loaded only in the lane before a full window
    logic [MEMBERS-1:0][KW2_LIM:1] end_masked;
    logic [MEMBERS-1:0]            end_masked_en;

    logic [BITS_KW-1:0]              clr_left_in;
    logic [BITS_KW-1:0]              clr_left;
    logic [MEMBERS-1:0][BITS_KW-1:0] clr_right;
    logic                            not_start;

    // elaboration-time tables, indexed by kernel half width
    logic [KW2_LIM:1][KW2_LIM:0][BITS_KW-1:0] left_lut;
    logic [MEMBERS-1:0][KW2_LIM:0]            next_full_lut;
    logic [KW2_LIM:0][SW_MAX-1:0][BITS_OUT_SHIFT-1:0] shift_b_lut;

    assign is_config   = ctrl.kind == BEAT_CONFIG;
    assign is_cin_last = ctrl.kind == BEAT_CIN_LAST;

    // chains advance once per column, or restart on config
    assign reg_en = ctrl.beat && (is_config || is_cin_last);

    for (genvar k = 0; k <= KW2_LIM; k++) begin : g_kw
        localparam int KW = 2 * k + 1;

        // left = 2p - 1 + kw - KW_MAX, nothing below 1 and nothing for kw = 1
        for (genvar p = 1; p <= KW2_LIM; p++) begin : g_left
            localparam int LC = 2 * p - 1 + KW - KW_MAX;
            localparam int LC_POS = (k == 0 || LC < 0) ? 0 : LC;
            assign left_lut[p][k] = BITS_KW'(LC_POS);
        end

        // lane m is one short of a full window when m % kw == kw - 2
        for (genvar m = 0; m < MEMBERS; m++) begin : g_full
            assign next_full_lut[m][k] = (k == 0) ? 1'b1 : ((m % KW) == KW - 2);
        end

        // output groups per beat minus one
        for (genvar s = 0; s < SW_MAX; s++) begin : g_sw
            localparam int SB = (k == 0) ? 0 : MEMBERS / (KW + s) - 1;
            assign shift_b_lut[k][s] = BITS_OUT_SHIFT'(SB);
        end
    end

    // row end pulse enters at column cols-1-kw2
    assign col_end_in[1] = ctrl.cols_1_k2 && (ctrl.kw2 != 0);

    // config seeds the start chain, later the end of a row re-seeds it
    assign col_start_in[1] = is_config ? (ctrl.kw2 != 0) : col_end[ctrl.kw2];

    for (genvar k = 2; k <= KW2_LIM; k++) begin : g_chain
        assign col_end_in[k]   = col_end[k-1];
        assign col_start_in[k] = is_config ? 1'b0 : col_start[k-1];
    end

    // bit 0 is a constant zero so kw2 = 0 reads as no end
    assign col_end = {col_end_q, 1'b0};

    // left code from the one-hot start vector before it shifts
    always_comb begin
        clr_left_in = '0;
        for (int p = 1; p <= KW2_LIM; p++) begin
            if (col_start[p]) begin
                clr_left_in = left_lut[p][ctrl.kw2];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            col_end_q <= '0;
            col_start <= '0;
            clr_left  <= BITS_KW'(1);
        end else if (reg_en) begin
            col_end_q <= col_end_in;
            col_start <= col_start_in;
            clr_left  <= clr_left_in;
        end
    end

    // end copies load on cin-last beats in the lane just before full
    always_comb begin
        for (int m = 0; m < MEMBERS; m++) begin
            end_masked_en[m] = ctrl.beat && is_cin_last && next_full_lut[m][ctrl.kw2];
        end
    end

    always_ff @(posedge aclk) begin
        for (int m = 0; m < MEMBERS; m++) begin
            if (rst) begin
                end_masked[m] <= '0;
            end else if (end_masked_en[m]) begin
                end_masked[m] <= col_end_in;
            end
        end
    end

    // right = 2q for end bit q, merged with the shared left code
    always_comb begin
        for (int m = 0; m < MEMBERS; m++) begin
            clr_right[m] = '0;
            for (int q = 1; q <= KW2_LIM; q++) begin
                if (end_masked[m][q]) begin
                    clr_right[m] = BITS_KW'(2 * q);
                end
            end
            clr[m] = clr_left | clr_right[m];
            // a 1-wide kernel never pads
            if (ctrl.kw2 == 0) begin
                clr[m] = '0;
            end
        end
    end

    // first kw2 columns of a row only prime the window
    always_comb begin
        not_start = 1'b1;
        for (int p = 1; p <= KW2_LIM; p++) begin
            if (p <= int'(ctrl.kw2) && col_start[p]) begin
                not_start = 1'b0;
            end
        end
    end

    assign valid_mask = (not_start && ctrl.col_valid) || is_config;

    assign shift_a = col_end[ctrl.kw2] ? BITS_MEMBERS'(ctrl.kw2) : '0;
    assign shift_b = shift_b_lut[ctrl.kw2][ctrl.sw_1];

    // one row pulse at a time travels through each chain
    assert property (@(posedge aclk) disable iff (rst) $onehot0(col_start))
        else $error("column start chain holds %b", col_start);

    assert property (@(posedge aclk) disable iff (rst) $onehot0(col_end))
        else $error("column end chain holds %b", col_end);

endmodule

// File: tuser_decode.sv
// user word decoder: splits fields, clamps unsupported kernels and classifies each beat
`timescale 1ns/1ps

module tuser_decode
    import conv_geom_pkg::*, tuser_pkg::*;
#(
    parameter int KW_MAX = conv_geom_pkg::KW_MAX
) (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   aclken,
    input  logic                   valid_in,
    input  logic [TUSER_WIDTH-1:0] user_in,
    output logic                   cfg_error,
    pad_ctrl_if.dec                ctrl
);

    // largest half width this build handles
    localparam int KW2_LIM = KW_MAX / 2;

    logic                beat;
    logic [BITS_KW2-1:0] kw2_raw;
    logic                kw2_bad;
    beat_kind_e          kind;

    // a beat is taken only when the clock enable and strobe agree
    assign beat = aclken && valid_in;

    assign kw2_raw = user_in[I_KW2 +: BITS_KW2];

    // a kernel wider than the build falls back to kw = 1
    assign kw2_bad = int'(kw2_raw) > KW2_LIM;

    // flagged for the current beat only
    assign cfg_error = beat && kw2_bad;

    // beat classification, config first
    always_comb begin
        if (!beat) begin
            kind = BEAT_IDLE;
        end else if (user_in[I_IS_CONFIG]) begin
            kind = BEAT_CONFIG;
        end else if (user_in[I_IS_CIN_LAST]) begin
            kind = BEAT_CIN_LAST;
        end else begin
            kind = BEAT_DATA;
        end
    end

    assign ctrl.beat      = beat;
    assign ctrl.kind      = kind;
    assign ctrl.kw2       = kw2_bad ? '0 : kw2_raw;
    assign ctrl.sw_1      = user_in[I_SW_1 +: BITS_SW];
    assign ctrl.cols_1_k2 = user_in[I_IS_COLS_1_K2];
    assign ctrl.col_valid = user_in[I_IS_COL_VALID];

    // downstream stages trust kind alone, so it must never appear without a transfer
    assert property (@(posedge aclk) disable iff (rst)
        (ctrl.kind != BEAT_IDLE) |-> ctrl.beat)
        else $error("beat kind %s without a transfer", ctrl.kind.name());

endmodule

// File: pad_ctrl_if.sv
// decoded beat fields passed from the user word decoder to the mask and output stages
`timescale 1ns/1ps

interface pad_ctrl_if
    import conv_geom_pkg::*, tuser_pkg::*;
();

    // transfer strobe, valid_in and aclken both high
    logic beat;

    // classification of the current beat
    beat_kind_e kind;

    // kernel half width after clamping
    logic [BITS_KW2-1:0] kw2;

    // stride minus one
    logic [BITS_SW-1:0] sw_1;

    // row end marker and column validity
    logic cols_1_k2;
    logic col_valid;

    // decoder drives every field
    modport dec (output beat, kind, kw2, sw_1, cols_1_k2, col_valid);

    // mask logic reads the full set
    modport exe (input beat, kind, kw2, sw_1, cols_1_k2, col_valid);

    // output stage only needs the strobe and kind
    modport res (input beat, kind);

endinterface

// File: tuser_pkg.sv
// side-band user word layout for input beats and the beat kind enum
package tuser_pkg;

    // kernel half width, two bits starting here
    localparam int I_KW2 = 0;

    // stride minus one
    localparam int I_SW_1 = 2;

    // beat carries a new kernel/stride setting
    localparam int I_IS_CONFIG = 3;

    // last input channel of the current column
    localparam int I_IS_CIN_LAST = 4;

    // column index equals cols-1-kw2
    localparam int I_IS_COLS_1_K2 = 5;

    // column holds real pixels
    localparam int I_IS_COL_VALID = 6;

    // total user word width
    localparam int TUSER_WIDTH = 7;

    // what a beat means to the padding logic
    // config wins over cin-last when both flags are set
    typedef enum logic [1:0] {
        BEAT_IDLE     = 2'd0,
        BEAT_CONFIG   = 2'd1,
        BEAT_DATA     = 2'd2,
        BEAT_CIN_LAST = 2'd3
    } beat_kind_e;

endpackage

// File: conv_geom_pkg.sv
// convolution geometry: default kernel, stride and lane sizes with the widths derived from them
package conv_geom_pkg;

    // largest odd kernel width supported by the padding logic
    localparam int KW_MAX = 7;

    // half of the largest kernel, 7 -> 3, 5 -> 2, 3 -> 1
    localparam int KW2_MAX = KW_MAX / 2;

    // largest horizontal stride
    localparam int SW_MAX = 2;

    // parallel lanes through the datapath
    localparam int MEMBERS = 8;

    // bits per lane of pixel data
    localparam int DATA_WIDTH = 8;

    // one centre/left/right code per lane
    // left codes are odd, right codes even, so the or of both still fits
    localparam int BITS_KW = $clog2(KW_MAX + 1) + 1;

    // kw2 field, 0 .. KW2_MAX
    localparam int BITS_KW2 = $clog2(KW2_MAX + 1);

    // stride minus one
    localparam int BITS_SW = $clog2(SW_MAX);

    // shift_a counts lanes
    localparam int BITS_MEMBERS = $clog2(MEMBERS);

    // shift_b counts output groups per beat
    localparam int BITS_OUT_SHIFT = $clog2(MEMBERS);

endpackage
